//--- sys_mem_part_mngr_regmap.svh
// Partition manager host register addresses

// Bit 0 selects config mode when set
localparam logic [sys_mem_pkg::LB_ADDR_W-1:0] CNTRL_REG      = 8'h00;
// Number of agents, read only
localparam logic [sys_mem_pkg::LB_ADDR_W-1:0] NUM_AGENTS_REG = 8'h04;
// Agent selected for table access by the host
localparam logic [sys_mem_pkg::LB_ADDR_W-1:0] ADDR_REG       = 8'h08;
// Start address of the selected agent
localparam logic [sys_mem_pkg::LB_ADDR_W-1:0] START_DATA_REG = 8'h0C;
// End address of the selected agent, inclusive
localparam logic [sys_mem_pkg::LB_ADDR_W-1:0] END_DATA_REG   = 8'h10;

//--- sys_mem_pkg.sv
// Shared types and widths for the shared-memory subsystem
package sys_mem_pkg;

  // Word address width of the data memory, 1024 words
  localparam int MEM_ADDR_W = 10;
  // Data word width
  localparam int DATA_W = 32;

  // Local host bus widths
  localparam int LB_ADDR_W = 8;
  localparam int LB_DATA_W = 32;

  // Read-back value for unmapped host registers
  localparam logic [LB_DATA_W-1:0] DEFAULT_RD_VAL = 32'hdeadbabe;

  // One agent request, held until done
  typedef struct packed {
    logic                  wr;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } mem_req_t;

  // Response returned with done
  typedef struct packed {
    logic              err;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Inclusive word address limits of one agent
  typedef struct packed {
    logic [MEM_ADDR_W-1:0] start_addr;
    logic [MEM_ADDR_W-1:0] end_addr;
  } part_t;

  // Host strobes, single cycle
  typedef struct packed {
    logic                 wr_en;
    logic                 rd_en;
    logic [LB_ADDR_W-1:0] addr;
    logic [LB_DATA_W-1:0] wdata;
  } lb_req_t;

  // Host answer, valid pulses one cycle after the strobe
  typedef struct packed {
    logic                 wr_valid;
    logic                 rd_valid;
    logic [LB_DATA_W-1:0] rd_data;
  } lb_rsp_t;

  // Access sequencer states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    ACCESS,
    RESP
  } arb_state_e;

endpackage

//--- sync_spram.sv
`timescale 1ns/100ps

module sync_spram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 256
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         wdata,
  input  logic                     wren,
  output logic [WIDTH-1:0]         q
);

  // Storage array
  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk)
  begin
    // Write on the edge when enabled
    if (wren)
    begin
      mem[addr] <= wdata;
    end
    // Registered read, old data on a same-address write
    q <= mem[addr];
  end

endmodule

//--- sys_mem_part_mngr.sv
`timescale 1ns/100ps

module sys_mem_part_mngr #(
  parameter int NUM_AGENTS = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  sys_mem_pkg::lb_req_t          lb_req,
  output sys_mem_pkg::lb_rsp_t          lb_rsp,
  input  logic [$clog2(NUM_AGENTS)-1:0] agent_id,
  output sys_mem_pkg::part_t            part,
  output logic                          cfg_mode
);

  import sys_mem_pkg::*;

  `include "sys_mem_part_mngr_regmap.svh"

  localparam int AID_W = $clog2(NUM_AGENTS);

  // Agent picked by the host for table access
  logic [AID_W-1:0]      hst_sel;
  // Shared table RAM address and write data
  logic [AID_W-1:0]      tbl_addr;
  logic [MEM_ADDR_W-1:0] tbl_wdata;
  logic                  start_wren;
  logic                  end_wren;
  logic [MEM_ADDR_W-1:0] start_q;
  logic [MEM_ADDR_W-1:0] end_q;

  // Host writes to mode and agent select
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg_mode <= 1'b0;
      hst_sel  <= '0;
    end
    else if (lb_req.wr_en)
    begin
      case (lb_req.addr)
        CNTRL_REG:
        begin
          cfg_mode <= lb_req.wdata[0];
        end
        ADDR_REG:
        begin
          hst_sel <= lb_req.wdata[AID_W-1:0];
        end
        default:
        begin
        end
      endcase
    end
  end

  // Host answer one cycle after each strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lb_rsp <= '0;
    end
    else
    begin
      lb_rsp.wr_valid <= lb_req.wr_en;
      lb_rsp.rd_valid <= lb_req.rd_en;
      // Read data held until the next read
      if (lb_req.rd_en)
      begin
        case (lb_req.addr)
          CNTRL_REG:      lb_rsp.rd_data <= LB_DATA_W'(cfg_mode);
          NUM_AGENTS_REG: lb_rsp.rd_data <= LB_DATA_W'(NUM_AGENTS);
          ADDR_REG:       lb_rsp.rd_data <= LB_DATA_W'(hst_sel);
          // Table output of the currently addressed entry
          START_DATA_REG: lb_rsp.rd_data <= LB_DATA_W'(start_q);
          END_DATA_REG:   lb_rsp.rd_data <= LB_DATA_W'(end_q);
          default:        lb_rsp.rd_data <= DEFAULT_RD_VAL;
        endcase
      end
    end
  end

  // Host owns the tables in config mode, arbiter otherwise
  assign tbl_addr  = cfg_mode ? hst_sel : agent_id;
  assign tbl_wdata = lb_req.wdata[MEM_ADDR_W-1:0];

  // Table writes only while the host owns the address
  assign start_wren = cfg_mode && lb_req.wr_en && (lb_req.addr == START_DATA_REG);
  assign end_wren   = cfg_mode && lb_req.wr_en && (lb_req.addr == END_DATA_REG);

  // Limits of the addressed agent, one cycle after the address
  assign part = '{start_addr: start_q, end_addr: end_q};

  sync_spram #(
    .WIDTH (MEM_ADDR_W),
    .DEPTH (NUM_AGENTS)
  ) start_ram (
    .clk   (clk),
    .addr  (tbl_addr),
    .wdata (tbl_wdata),
    .wren  (start_wren),
    .q     (start_q)
  );

  sync_spram #(
    .WIDTH (MEM_ADDR_W),
    .DEPTH (NUM_AGENTS)
  ) end_ram (
    .clk   (clk),
    .addr  (tbl_addr),
    .wdata (tbl_wdata),
    .wren  (end_wren),
    .q     (end_q)
  );

  // Host issues one strobe type per cycle
  a_lb_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
    !(lb_req.wr_en && lb_req.rd_en));

endmodule

//--- sys_mem_arb.sv
`timescale 1ns/100ps

module sys_mem_arb #(
  parameter int NUM_AGENTS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [NUM_AGENTS-1:0]                  req,
  input  sys_mem_pkg::mem_req_t [NUM_AGENTS-1:0] agent_req,
  output logic [NUM_AGENTS-1:0]                  done,
  output sys_mem_pkg::mem_rsp_t                  rsp,
  output logic [$clog2(NUM_AGENTS)-1:0]          agent_id,
  input  sys_mem_pkg::part_t                     part,
  input  logic                                   cfg_mode
);

  import sys_mem_pkg::*;

  localparam int AID_W = $clog2(NUM_AGENTS);

  arb_state_e        state;
  // Next agent by round-robin scan
  logic [AID_W-1:0]  winner;
  logic              found;
  // Granted request, held through the access
  mem_req_t          cur_req;
  logic              in_range;
  logic              err_q;
  logic              mem_wren;
  logic [DATA_W-1:0] mem_q;

  // Scan starts one past the last winner, held in agent_id
  always_comb
  begin
    int cand;
    winner = agent_id;
    found  = 1'b0;
    for (int i = 1; i <= NUM_AGENTS; i++)
    begin
      cand = (int'(agent_id) + i) % NUM_AGENTS;
      if (!found && req[cand])
      begin
        found  = 1'b1;
        winner = AID_W'(cand);
      end
    end
  end

  // Sequencer, four cycles per access including IDLE
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      // First scan starts at agent 0
      agent_id <= AID_W'(NUM_AGENTS - 1);
    end
    else
    begin
      case (state)
        IDLE:
        begin
          // No new grants while the host reprograms
          if (!cfg_mode && found)
          begin
            agent_id <= winner;
            state    <= LOOKUP;
          end
        end
        // Partition tables read agent_id here
        LOOKUP:  state <= ACCESS;
        ACCESS:  state <= RESP;
        RESP:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Request capture at grant and limit result at access
  always_ff @(posedge clk)
  begin
    if (state == IDLE)
    begin
      cur_req <= agent_req[winner];
    end
    if (state == ACCESS)
    begin
      err_q <= !in_range;
    end
  end

  // Inclusive limit check against the returned partition
  assign in_range = (cur_req.addr >= part.start_addr) && (cur_req.addr <= part.end_addr);

  // Write only inside the partition
  assign mem_wren = (state == ACCESS) && cur_req.wr && in_range;

  // One-cycle done to the granted agent
  assign done = (state == RESP) ? (NUM_AGENTS'(1) << agent_id) : '0;

  // Zero data on errors and writes
  assign rsp = '{
    err:   (state == RESP) && err_q,
    rdata: (state == RESP && !err_q && !cur_req.wr) ? mem_q : '0
  };

  sync_spram #(
    .WIDTH (DATA_W),
    .DEPTH (1 << MEM_ADDR_W)
  ) data_ram (
    .clk   (clk),
    .addr  (cur_req.addr),
    .wdata (cur_req.wdata),
    .wren  (mem_wren),
    .q     (mem_q)
  );

  // Granted agent holds its request until done
  a_grant_held : assert property (@(posedge clk) disable iff (!rst_n)
    (state != IDLE) |-> req[agent_id]);

  // Granted request stays steady through the access
  a_req_steady : assert property (@(posedge clk) disable iff (!rst_n)
    (state != IDLE) |-> (agent_req[agent_id] == cur_req));

endmodule

//--- sys_mem_subsys.sv
`timescale 1ns/100ps

module sys_mem_subsys #(
  parameter int NUM_AGENTS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Host programming bus
  input  sys_mem_pkg::lb_req_t                   lb_req,
  output sys_mem_pkg::lb_rsp_t                   lb_rsp,
  // Agent ports
  input  logic [NUM_AGENTS-1:0]                  req,
  input  sys_mem_pkg::mem_req_t [NUM_AGENTS-1:0] agent_req,
  output logic [NUM_AGENTS-1:0]                  done,
  output sys_mem_pkg::mem_rsp_t                  rsp
);

  import sys_mem_pkg::*;

  // Granted agent, drives the table lookup
  logic [$clog2(NUM_AGENTS)-1:0] agent_id;
  // Limits of the granted agent
  part_t                         part;
  // Host reprogramming, stalls new grants
  logic                          cfg_mode;

  // Partition tables and host registers
  sys_mem_part_mngr #(
    .NUM_AGENTS (NUM_AGENTS)
  ) u_part_mngr (
    .clk      (clk),
    .rst_n    (rst_n),
    .lb_req   (lb_req),
    .lb_rsp   (lb_rsp),
    .agent_id (agent_id),
    .part     (part),
    .cfg_mode (cfg_mode)
  );

  // Arbiter, limit check and data memory
  sys_mem_arb #(
    .NUM_AGENTS (NUM_AGENTS)
  ) u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .agent_req (agent_req),
    .done      (done),
    .rsp       (rsp),
    .agent_id  (agent_id),
    .part      (part),
    .cfg_mode  (cfg_mode)
  );

endmodule

//--- tb_sys_mem.sv
`timescale 1ns/100ps

module tb_sys_mem;

  import sys_mem_pkg::*;

  `include "sys_mem_part_mngr_regmap.svh"

  localparam int N_AGENTS    = 4;
  // Partition layout, agent i owns PART_LEN words at i*PART_STRIDE+PART_BASE
  localparam int PART_BASE   = 8;
  localparam int PART_STRIDE = 64;
  localparam int PART_LEN    = 16;
  localparam int LB_TIMEOUT  = 4;
  localparam int WATCHDOG    = 20000;

  logic                    clk;
  logic                    rst_n;
  lb_req_t                 lb_req;
  lb_rsp_t                 lb_rsp;
  logic [N_AGENTS-1:0]     req;
  mem_req_t [N_AGENTS-1:0] agent_req;
  logic [N_AGENTS-1:0]     done;
  mem_rsp_t                rsp;

  // Model memory and partition table
  logic [DATA_W-1:0]     model_mem [1 << MEM_ADDR_W];
  logic [MEM_ADDR_W-1:0] model_start [N_AGENTS];
  logic [MEM_ADDR_W-1:0] model_end [N_AGENTS];
  // Per waiting agent, which other agents were granted meanwhile
  logic [N_AGENTS-1:0]   seen_grant [N_AGENTS] = '{default: '0};

  int errors     = 0;
  int chk_errors = 0;
  int done_cnt   = 0;
  int cyc        = 0;

  sys_mem_subsys #(
    .NUM_AGENTS (N_AGENTS)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .lb_req    (lb_req),
    .lb_rsp    (lb_rsp),
    .req       (req),
    .agent_req (agent_req),
    .done      (done),
    .rsp       (rsp)
  );

  // 40 ns clock
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cycle count for latency checks
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  function automatic int part_lo(input int id);
    return id * PART_STRIDE + PART_BASE;
  endfunction

  function automatic int part_hi(input int id);
    return part_lo(id) + PART_LEN - 1;
  endfunction

  // Expected response, inclusive limits; errors leave the memory alone
  function automatic mem_rsp_t ref_access(input int agent, input mem_req_t r);
    mem_rsp_t exp;
    exp = '0;
    if (r.addr < model_start[agent] || r.addr > model_end[agent])
    begin
      exp.err = 1'b1;
    end
    else if (r.wr)
    begin
      model_mem[r.addr] = r.wdata;
    end
    else
    begin
      exp.rdata = model_mem[r.addr];
    end
    return exp;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Valid is due at the first falling edge after the strobe
  task automatic wait_lb_valid(input bit is_rd, input logic [LB_ADDR_W-1:0] addr);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(is_rd ? lb_rsp.rd_valid : lb_rsp.wr_valid) && waited < LB_TIMEOUT)
    begin
      waited++;
      @(negedge clk);
    end
    assert (waited == 0)
    else
    begin
      errors++;
      $display("Local bus strobe to %h got no valid pulse one cycle later", addr);
    end
  endtask

  task automatic lb_write(input logic [LB_ADDR_W-1:0] addr, input logic [LB_DATA_W-1:0] data);
    @(posedge clk);
    #2;
    lb_req.wr_en = 1'b1;
    lb_req.addr  = addr;
    lb_req.wdata = data;
    @(posedge clk);
    #2;
    lb_req.wr_en = 1'b0;
    wait_lb_valid(1'b0, addr);
  endtask

  task automatic lb_read(input logic [LB_ADDR_W-1:0] addr, output logic [LB_DATA_W-1:0] data);
    @(posedge clk);
    #2;
    lb_req.rd_en = 1'b1;
    lb_req.addr  = addr;
    @(posedge clk);
    #2;
    lb_req.rd_en = 1'b0;
    wait_lb_valid(1'b1, addr);
    data = lb_rsp.rd_data;
  endtask

  // Request level held until done, dropped on the next edge
  task automatic agent_access(input int id, input bit wr, input int addr,
                              input logic [DATA_W-1:0] wdata, input int max_wait,
                              input bit chk_lat);
    int start_cyc;
    int waited;
    @(posedge clk);
    #2;
    agent_req[id].wr    = wr;
    agent_req[id].addr  = MEM_ADDR_W'(addr);
    agent_req[id].wdata = wdata;
    req[id]             = 1'b1;
    start_cyc           = cyc;
    waited              = 0;
    @(negedge clk);
    while (!done[id] && waited < max_wait)
    begin
      waited++;
      @(negedge clk);
    end
    if (!done[id])
    begin
      errors++;
      $display("Agent %0d saw no done pulse within %0d cycles", id, max_wait);
    end
    else if (chk_lat)
    begin
      check_word($sformatf("done[%0d] latency", id), 3, cyc - start_cyc);
    end
    @(posedge clk);
    #2;
    req[id] = 1'b0;
  endtask

  // Random read or write inside the agent's own partition
  task automatic random_access(input int id, input int max_wait);
    bit                wr;
    int                addr;
    logic [DATA_W-1:0] wdata;
    wr    = ($urandom % 2) == 1;
    addr  = part_lo(id) + int'($urandom % PART_LEN);
    wdata = $urandom;
    agent_access(id, wr, addr, wdata, max_wait, 1'b0);
  endtask

  task automatic agent_burst(input int id, input int count);
    repeat (count)
    begin
      random_access(id, 24);
    end
  endtask

  // Response checker, one compare per done pulse
  always @(negedge clk)
  begin
    mem_rsp_t exp;
    int       a;
    if (rst_n && (done !== '0))
    begin
      a = 0;
      for (int i = 0; i < N_AGENTS; i++)
      begin
        if (done[i])
        begin
          a = i;
        end
      end
      assert ($onehot(done))
      else
      begin
        chk_errors++;
        $display("Several done pulses at once at %0t, done=%b", $time, done);
      end
      assert (req[a])
      else
      begin
        chk_errors++;
        $display("Done to agent %0d at %0t without a pending request", a, $time);
      end
      exp = ref_access(a, agent_req[a]);
      assert (rsp.err === exp.err)
      else
      begin
        chk_errors++;
        $display("ERR %0t rsp.err expected %b got %b", $time, exp.err, rsp.err);
      end
      assert (rsp.rdata === exp.rdata)
      else
      begin
        chk_errors++;
        $display("ERR %0t rsp.rdata expected %h got %h", $time, exp.rdata, rsp.rdata);
      end
      // Round-robin, one grant per agent while another waits
      for (int j = 0; j < N_AGENTS; j++)
      begin
        if (j != a && req[j])
        begin
          assert (!seen_grant[j][a])
          else
          begin
            chk_errors++;
            $display("Agent %0d granted twice while agent %0d waited", a, j);
          end
          seen_grant[j][a] = 1'b1;
        end
      end
      seen_grant[a] = '0;
      done_cnt++;
    end
  end

  initial
  begin
    logic [LB_DATA_W-1:0] rd;
    int                   stall_base;
    rst_n     = 1'b0;
    req       = '0;
    agent_req = '0;
    lb_req    = '0;
    void'($urandom(32'hc3da1c39));
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Register access after reset
    lb_read(CNTRL_REG, rd);
    check_word("lb_rsp.rd_data CNTRL_REG", 0, rd);
    lb_read(NUM_AGENTS_REG, rd);
    check_word("lb_rsp.rd_data NUM_AGENTS_REG", N_AGENTS, rd);
    lb_read(8'h24, rd);
    check_word("lb_rsp.rd_data unmapped", DEFAULT_RD_VAL, rd);

    // Disjoint partitions, programmed and read back in config mode
    lb_write(CNTRL_REG, 1);
    for (int i = 0; i < N_AGENTS; i++)
    begin
      lb_write(ADDR_REG, i);
      lb_write(START_DATA_REG, part_lo(i));
      lb_write(END_DATA_REG, part_hi(i));
      model_start[i] = MEM_ADDR_W'(part_lo(i));
      model_end[i]   = MEM_ADDR_W'(part_hi(i));
    end
    for (int i = 0; i < N_AGENTS; i++)
    begin
      lb_write(ADDR_REG, i);
      lb_read(START_DATA_REG, rd);
      check_word($sformatf("lb_rsp.rd_data START agent %0d", i), part_lo(i), rd);
      lb_read(END_DATA_REG, rd);
      check_word($sformatf("lb_rsp.rd_data END agent %0d", i), part_hi(i), rd);
    end
    lb_write(CNTRL_REG, 0);

    // Fill every partition word, then read it all back
    for (int i = 0; i < N_AGENTS; i++)
    begin
      for (int w = 0; w < PART_LEN; w++)
      begin
        agent_access(i, 1'b1, part_lo(i) + w, $urandom, 8, 1'b1);
      end
      for (int w = 0; w < PART_LEN; w++)
      begin
        agent_access(i, 1'b0, part_lo(i) + w, '0, 8, 1'b1);
      end
    end

    // Just outside own limits and inside both neighbours' partitions
    for (int i = 0; i < N_AGENTS; i++)
    begin
      agent_access(i, 1'b1, part_lo(i) - 1, $urandom, 8, 1'b1);
      agent_access(i, 1'b1, part_hi(i) + 1, $urandom, 8, 1'b1);
      agent_access(i, 1'b0, part_lo(i) - 1, '0, 8, 1'b1);
      agent_access(i, 1'b0, part_hi(i) + 1, '0, 8, 1'b1);
      agent_access(i, 1'b1, part_lo((i + 1) % N_AGENTS), $urandom, 8, 1'b1);
      agent_access(i, 1'b0, part_lo((i + 1) % N_AGENTS), '0, 8, 1'b1);
      agent_access(i, 1'b1, part_hi((i + N_AGENTS - 1) % N_AGENTS), $urandom, 8, 1'b1);
      agent_access(i, 1'b0, part_hi((i + N_AGENTS - 1) % N_AGENTS), '0, 8, 1'b1);
    end
    // Owners read back the targeted words
    for (int i = 0; i < N_AGENTS; i++)
    begin
      agent_access(i, 1'b0, part_lo(i), '0, 8, 1'b1);
      agent_access(i, 1'b0, part_hi(i), '0, 8, 1'b1);
    end

    // All agents at once
    fork
      agent_burst(0, 8);
      agent_burst(1, 8);
      agent_burst(2, 8);
      agent_burst(3, 8);
    join

    // Config mode set one cycle after the requests rise
    fork
      random_access(0, 100);
      random_access(1, 100);
      random_access(2, 100);
      random_access(3, 100);
      begin
        @(posedge clk);
        lb_write(CNTRL_REG, 1);
        stall_base = done_cnt;
        repeat (20) @(posedge clk);
        assert (done_cnt - stall_base <= 1)
        else
        begin
          errors++;
          $display("%0d done pulses arrived in config mode", done_cnt - stall_base);
        end
        lb_write(CNTRL_REG, 0);
      end
    join

    repeat (4) @(posedge clk);
    $display("Errors: %0d stimulus, %0d response", errors, chk_errors);
    if (errors + chk_errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Run limit
  initial
  begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Run did not complete within %0d cycles", WATCHDOG);
    $display("Errors: %0d stimulus, %0d response", errors, chk_errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
sys_mem_pkg.sv
sync_spram.sv
sys_mem_part_mngr.sv
sys_mem_arb.sv
sys_mem_subsys.sv
tb_sys_mem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sys_mem
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
